// ==== note_lanes.sv ====
module note_lanes
	import rhythm_pkg::*;
#(
	parameter int STEP_CYCLES = 500000
)(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   spawn_valid,
	input  lane_t  spawn_lane,
	output logic   spawn_ready,
	input  logic [3:0] pad,
	output logic   judge_valid,
	output judge_t judge,
	output field_t field,
	output grade_t last_grade
);

	localparam int CNT_W = $clog2(STEP_CYCLES + 1);

	logic [3:0][SLOTS_PER_LANE-1:0] act;
	logic [3:0][SLOTS_PER_LANE-1:0] tick;
	offset_t off [4][SLOTS_PER_LANE];
	logic [CNT_W-1:0] step_cnt [4][SLOTS_PER_LANE];
	logic [3:0] pad_q;
	logic [3:0] press;
	logic [1:0] free_slot;
	logic spawn_go;
	logic [1:0] near_slot [4];
	grade_t lane_grade [4];
	logic judge_hit;
	lane_t judge_lane;

	assign press = pad_q & ~pad;   // pads are active low
	assign spawn_ready = ~&act[spawn_lane];
	assign spawn_go = spawn_valid && spawn_ready;

	always_comb
	begin
		free_slot = '0;
		for (int s = SLOTS_PER_LANE - 1; s >= 0; s--)
			if (!act[spawn_lane][s])
				free_slot = 2'(s);   // lowest free slot wins
	end

	always_comb
	begin
		for (int l = 0; l < 4; l++)
			for (int s = 0; s < SLOTS_PER_LANE; s++)
			begin
				tick[l][s] = act[l][s] && (step_cnt[l][s] == CNT_W'(STEP_CYCLES - 1));
				field[l][s] = '{active: act[l][s], offset: off[l][s]};
			end
	end

	// per lane, the active note nearest the target and its grade
	always_comb
	begin
		offset_t best;
		logic found;
		for (int l = 0; l < 4; l++)
		begin
			best = '1;
			found = 1'b0;
			near_slot[l] = '0;
			for (int s = 0; s < SLOTS_PER_LANE; s++)
				if (act[l][s] && (!found || off[l][s] < best))
				begin
					found = 1'b1;
					best = off[l][s];
					near_slot[l] = 2'(s);
				end
			if (!found || best >= MISS_WIN)
				lane_grade[l] = GRADE_NONE;
			else if (best < ON_TIME_WIN)
				lane_grade[l] = GRADE_ON_TIME;
			else if (best < EARLY_WIN)
				lane_grade[l] = GRADE_EARLY;
			else
				lane_grade[l] = GRADE_MISS;
		end
	end

	// one judgement per cycle, lowest graded lane first
	always_comb
	begin
		judge_hit = 1'b0;
		judge_lane = LANE_LEFT;
		for (int l = 3; l >= 0; l--)
			if (press[l] && lane_grade[l] != GRADE_NONE)
			begin
				judge_hit = 1'b1;
				judge_lane = lane_t'(l);
			end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			act <= '0;
			pad_q <= '1;
			judge_valid <= 1'b0;
			last_grade <= GRADE_NONE;
		end
		else
		begin
			pad_q <= pad;
			judge_valid <= judge_hit;
			if (judge_hit)
				last_grade <= lane_grade[judge_lane];
			for (int l = 0; l < 4; l++)
				for (int s = 0; s < SLOTS_PER_LANE; s++)
					if (spawn_go && spawn_lane == lane_t'(l) && free_slot == 2'(s))
						act[l][s] <= 1'b1;
					else if (judge_hit && judge_lane == lane_t'(l) && near_slot[l] == 2'(s))
						act[l][s] <= 1'b0;
					else if (tick[l][s] && off[l][s] == offset_t'(1))
						act[l][s] <= 1'b0;   // silent expiry at the target
		end
	end

	always_ff @(posedge clk)
	begin
		for (int l = 0; l < 4; l++)
			for (int s = 0; s < SLOTS_PER_LANE; s++)
				if (spawn_go && spawn_lane == lane_t'(l) && free_slot == 2'(s))
				begin
					off[l][s] <= offset_t'(START_OFFSET);
					step_cnt[l][s] <= '0;
				end
				else if (tick[l][s])
				begin
					off[l][s] <= off[l][s] - 1'b1;   // one pixel up
					step_cnt[l][s] <= '0;
				end
				else if (act[l][s])
					step_cnt[l][s] <= step_cnt[l][s] + 1'b1;
		judge <= '{lane: judge_lane, grade: lane_grade[judge_lane]};
	end

	for (genvar l = 0; l < 4; l++)
	begin : g_lane_chk
		// a lane that was full cannot gain a note on the next edge
		a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
			$past(rst_n) && (|(act[l] & ~$past(act[l]))) |-> !(&$past(act[l])));
		for (genvar s = 0; s < SLOTS_PER_LANE; s++)
		begin : g_slot_chk
			a_offset_range: assert property (@(posedge clk) disable iff (!rst_n)
				act[l][s] |-> off[l][s] <= START_OFFSET);
		end
	end

endmodule

// ==== note_painter.sv ====
module note_painter
	import rhythm_pkg::*;
(
	input  pix_t   pix,
	input  field_t field,
	output logic   note_hit,
	output lane_t  note_lane
);

	logic [3:0] lane_hit;

	// each note is a face-sized arrow pushed down by its offset
	always_comb
	begin
		int rx;
		int ry;
		for (int l = 0; l < 4; l++)
		begin
			lane_hit[l] = 1'b0;
			rx = int'(pix.x) - int'(LANE_X[l]);
			for (int s = 0; s < SLOTS_PER_LANE; s++)
			begin
				ry = int'(pix.y) - FRAME_Y - int'(field[l][s].offset);
				if (field[l][s].active && arrow_inside(lane_t'(l), rx, ry, 0))
					lane_hit[l] = 1'b1;
			end
		end
	end

	always_comb
	begin
		note_lane = LANE_LEFT;
		for (int l = 3; l >= 0; l--)
			if (lane_hit[l])
				note_lane = lane_t'(l);   // lowest lane on top
	end

	assign note_hit = |lane_hit;

endmodule

// ==== pixel_mixer.sv ====
module pixel_mixer
	import rhythm_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   pix_valid,
	input  pix_t   pix,
	input  logic   on_frame,
	input  logic   on_face,
	input  logic   note_hit,
	input  lane_t  note_lane,
	input  grade_t last_grade,
	output logic   rgb_valid,
	output rgb_t   rgb
);

	logic in_square;
	rgb_t colour;

	// grade indicator in the top left corner, bounds exclusive
	assign in_square = (last_grade != GRADE_NONE) &&
		(pix.x > IND_LO) && (pix.x < IND_HI) &&
		(pix.y > IND_LO) && (pix.y < IND_HI);

	always_comb
	begin
		if (in_square)
			colour = GRADE_COL[last_grade];
		else if (note_hit)
			colour = LANE_COL[note_lane];
		else if (on_frame)
			colour = COL_FRAME;
		else if (on_face)
			colour = COL_FACE;
		else
			colour = COL_BG;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= pix_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
			rgb <= colour;
	end

	// fixed one cycle latency from pixel request to colour
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> rgb_valid == $past(pix_valid));

endmodule

// ==== rhythm_display.sv ====
module rhythm_display
	import rhythm_pkg::*;
#(
	parameter int STEP_CYCLES = 500000
)(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   spawn_valid,
	input  lane_t  spawn_lane,
	output logic   spawn_ready,
	input  logic [3:0] pad,
	output logic   judge_valid,
	output judge_t judge,
	input  logic   pix_valid,
	input  pix_t   pix,
	output logic   rgb_valid,
	output rgb_t   rgb
);

	field_t field;
	grade_t last_grade;
	logic on_frame;
	logic on_face;
	logic note_hit;
	lane_t note_lane;

	note_lanes #(
		.STEP_CYCLES(STEP_CYCLES)
	) lanes_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.spawn_valid(spawn_valid),
		.spawn_lane (spawn_lane),
		.spawn_ready(spawn_ready),
		.pad        (pad),
		.judge_valid(judge_valid),
		.judge      (judge),
		.field      (field),
		.last_grade (last_grade)
	);

	target_painter targets_i (
		.pix     (pix),
		.on_frame(on_frame),
		.on_face (on_face)
	);

	// note painter runs alongside, same pixel
	note_painter notes_i (
		.pix      (pix),
		.field    (field),
		.note_hit (note_hit),
		.note_lane(note_lane)
	);

	pixel_mixer mixer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_valid (pix_valid),
		.pix       (pix),
		.on_frame  (on_frame),
		.on_face   (on_face),
		.note_hit  (note_hit),
		.note_lane (note_lane),
		.last_grade(last_grade),
		.rgb_valid (rgb_valid),
		.rgb       (rgb)
	);

endmodule

// ==== rhythm_pkg.sv ====
package rhythm_pkg;

	typedef enum logic [1:0] {
		LANE_LEFT,
		LANE_DOWN,
		LANE_UP,
		LANE_RIGHT
	} lane_t;

	typedef enum logic [1:0] {
		GRADE_NONE,
		GRADE_MISS,
		GRADE_EARLY,
		GRADE_ON_TIME
	} grade_t;

	typedef logic [10:0] coord_t;
	typedef logic [8:0] offset_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pix_t;

	typedef struct packed {
		logic [9:0] r;
		logic [9:0] g;
		logic [9:0] b;
	} rgb_t;

	typedef struct packed {
		logic    active;
		offset_t offset;
	} slot_t;

	localparam int SLOTS_PER_LANE = 3;

	typedef slot_t [SLOTS_PER_LANE-1:0] lane_slots_t;
	typedef lane_slots_t [3:0] field_t;

	typedef struct packed {
		lane_t  lane;
		grade_t grade;
	} judge_t;

	localparam int START_OFFSET = 336;   // spawn distance below the target row
	localparam int FRAME_Y = 36;
	localparam coord_t LANE_X [4] = '{11'd146, 11'd238, 11'd330, 11'd422};
	localparam int ARROW_BOX = 72;
	localparam int FRAME_GROW = 4;

	// offsets below each bound earn that grade
	localparam int MISS_WIN = 130;
	localparam int EARLY_WIN = 80;
	localparam int ON_TIME_WIN = 30;

	localparam logic [9:0] FULL = 10'h3ff;
	localparam rgb_t COL_BG = '{FULL, FULL, FULL};
	localparam rgb_t COL_FRAME = '{10'b1010101000, 10'b1010101000, 10'b1010101000};
	localparam rgb_t COL_FACE = '{FULL, FULL, FULL};
	localparam rgb_t COL_RED = '{FULL, 10'd0, 10'd0};
	localparam rgb_t COL_YELLOW = '{FULL, FULL, 10'd0};
	localparam rgb_t COL_GREEN = '{10'd0, FULL, 10'd0};
	localparam rgb_t COL_BLUE = '{10'd0, 10'd0, FULL};
	localparam rgb_t LANE_COL [4] = '{COL_RED, COL_YELLOW, COL_GREEN, COL_BLUE};
	localparam rgb_t GRADE_COL [4] = '{COL_BG, COL_RED, COL_YELLOW, COL_GREEN};   // by grade_t

	localparam int IND_LO = 20;
	localparam int IND_HI = 40;

	// every arrow is the left arrow turned, so map into its frame first:
	// u runs from the tip toward the stem, v across the arrow
	function automatic logic arrow_inside(lane_t lane, int rx, int ry, int grow);
		int u;
		int v;
		logic in_head;
		logic in_stem;
		case (lane)
			LANE_LEFT:
			begin
				u = rx;
				v = ry;
			end
			LANE_RIGHT:
			begin
				u = ARROW_BOX - rx;
				v = ry;
			end
			LANE_UP:
			begin
				u = ry;
				v = rx;
			end
			default:
			begin
				u = ARROW_BOX - ry;
				v = rx;
			end
		endcase
		in_head = (u >= -2 * grow) && (u <= ARROW_BOX / 2 + grow) &&
			(v - ARROW_BOX / 2 <= u + (3 * grow) / 2) &&
			(ARROW_BOX / 2 - v <= u + (3 * grow) / 2);
		in_stem = (u >= ARROW_BOX / 2) && (u <= ARROW_BOX + grow) &&
			(v >= ARROW_BOX / 4 - grow) && (v <= 3 * ARROW_BOX / 4 + grow);
		return in_head || in_stem;
	endfunction

endpackage

// ==== target_painter.sv ====
module target_painter
	import rhythm_pkg::*;
(
	input  pix_t pix,
	output logic on_frame,
	output logic on_face
);

	logic [3:0] inner;
	logic [3:0] grown;

	// the four outlined targets sit in one row
	always_comb
	begin
		int rx;
		int ry;
		for (int l = 0; l < 4; l++)
		begin
			rx = int'(pix.x) - int'(LANE_X[l]);
			ry = int'(pix.y) - FRAME_Y;
			inner[l] = arrow_inside(lane_t'(l), rx, ry, 0);
			grown[l] = arrow_inside(lane_t'(l), rx, ry, FRAME_GROW);
		end
	end

	// boxes are far enough apart that frames never touch a neighbour
	assign on_face = |inner;
	assign on_frame = |(grown & ~inner);   // outline ring only

endmodule

// ==== tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int SPAWN_WAIT = 50;
localparam int JUDGE_WAIT = 10;

task automatic fail_stop(input string why);
	$display("%s", why);
	$display("ERRORS FOUND");
	$fatal(1);
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
	if (got !== want)
	begin
		$display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, want);
		$display("ERRORS FOUND");
		$fatal(1);
	end
endtask

// every task starts and ends one time unit after a rising edge
task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic apply_reset();
	rst_n = 1'b0;
	spawn_valid = 1'b0;
	pad = '1;   // active low, all released
	pix_valid = 1'b0;
	repeat (2) next_cycle();
	rst_n = 1'b1;
endtask

// colour of the pixel as the field stands in the current cycle
task automatic sample_pixel(input int px, input int py, output rgb_t col);
	pix_valid = 1'b1;
	pix = '{x: coord_t'(px), y: coord_t'(py)};
	next_cycle();
	check_value(rgb_valid, 1'b1, "rgb_valid one cycle after a pixel request");
	col = rgb;
	pix_valid = 1'b0;
endtask

task automatic spawn_note(input lane_t lane, output int born);
	logic ready_seen;
	ready_seen = 1'b0;
	spawn_valid = 1'b1;
	spawn_lane = lane;
	for (int n = 0; n < SPAWN_WAIT && !ready_seen; n++)
	begin
		#3;
		ready_seen = spawn_ready;   // act only moves on edges
		next_cycle();
	end
	if (!ready_seen)
		fail_stop("a spawn request was never accepted");
	born = cycles;   // count of the accepting edge
	spawn_valid = 1'b0;
endtask

// one pixel up per STEP clocks after acceptance
function automatic int offset_at(input int born, input int now);
	return START_OFFSET - (now - born) / STEP;
endfunction

function automatic grade_t grade_for(input int off);
	if (off < 30)
		return GRADE_ON_TIME;
	else if (off < 80)
		return GRADE_EARLY;
	else if (off < 130)
		return GRADE_MISS;
	return GRADE_NONE;
endfunction

function automatic rgb_t grade_colour(input grade_t g);
	case (g)
		GRADE_MISS: return COL_RED;
		GRADE_EARLY: return COL_YELLOW;
		GRADE_ON_TIME: return COL_GREEN;
		default: return COL_BG;
	endcase
endfunction

task automatic wait_offset(input int born, input int target);
	for (int n = 0; n < START_OFFSET * STEP && offset_at(born, cycles) > target; n++)
		next_cycle();
	if (offset_at(born, cycles) > target)
		fail_stop("a note never scrolled down to the press offset");
endtask

task automatic press_expect_judge(input lane_t lane, output judge_t seen);
	logic got;
	got = 1'b0;
	pad[lane] = 1'b0;
	for (int n = 0; n < JUDGE_WAIT && !got; n++)
	begin
		next_cycle();
		got = judge_valid;
	end
	if (!got)
		fail_stop("no judge pulse followed a pad press on a graded note");
	seen = judge;
	pad[lane] = 1'b1;
	next_cycle();
	check_value(judge_valid, 1'b0, "judge pulse lasts one cycle");
endtask

task automatic press_expect_none(input lane_t lane);
	pad[lane] = 1'b0;
	for (int n = 0; n < 20; n++)
	begin
		next_cycle();
		check_value(judge_valid, 1'b0, "judge pulse after pressing an empty lane");
	end
	pad[lane] = 1'b1;
	next_cycle();
endtask

`endif

// ==== tb_rhythm_display.sv ====
module tb_rhythm_display
	import rhythm_pkg::*;
();

	localparam int STEP = 4;   // scroll period given to the DUT
	localparam int CLK_HALF = 4;
	localparam int RUN_LIMIT = 20000;

	logic clk;
	logic rst_n;
	logic spawn_valid;
	lane_t spawn_lane;
	logic spawn_ready;
	logic [3:0] pad;
	logic judge_valid;
	judge_t judge;
	logic pix_valid;
	pix_t pix;
	logic rgb_valid;
	rgb_t rgb;
	int cycles;

	rhythm_display #(
		.STEP_CYCLES(STEP)
	) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.spawn_valid(spawn_valid),
		.spawn_lane (spawn_lane),
		.spawn_ready(spawn_ready),
		.pad        (pad),
		.judge_valid(judge_valid),
		.judge      (judge),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.rgb_valid  (rgb_valid),
		.rgb        (rgb)
	);

	`include "tb_tasks.svh"

	always #CLK_HALF clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;   // edge count, offsets derive from it

	task automatic reset_and_background();
		rgb_t col;
		apply_reset();
		check_value(judge_valid, 1'b0, "judge_valid after reset");
		check_value(rgb_valid, 1'b0, "rgb_valid after reset");
		for (int l = 0; l < 4; l++)
		begin
			spawn_lane = lane_t'(l);
			#1;
			check_value(spawn_ready, 1'b1, "spawn_ready of an empty lane after reset");
			next_cycle();
		end
		sample_pixel(2000, 1500, col);
		check_value(col, COL_BG, "far corner background");
		sample_pixel(int'(LANE_X[0]) + 54, FRAME_Y + 16, col);   // just above the stem face
		check_value(col, COL_FRAME, "left arrow stem frame edge");
		sample_pixel(int'(LANE_X[0]) + 54, FRAME_Y + 36, col);
		check_value(col, COL_FACE, "left arrow stem centre");
	endtask

	task automatic full_lane_back_pressure();
		lane_t full_lane;
		lane_t other_lane;
		int born;
		apply_reset();
		full_lane = lane_t'($urandom_range(3, 0));
		other_lane = lane_t'((int'(full_lane) + 1 + $urandom_range(2, 0)) % 4);
		repeat (3) spawn_note(full_lane, born);
		spawn_valid = 1'b1;
		spawn_lane = full_lane;
		for (int n = 0; n < 8; n++)
		begin
			#3;
			check_value(spawn_ready, 1'b0, "spawn_ready of a full lane");
			next_cycle();
		end
		spawn_valid = 1'b0;
		next_cycle();
		spawn_note(other_lane, born);
		spawn_lane = full_lane;
		#1;
		check_value(spawn_ready, 1'b0, "full lane still full after a spawn elsewhere");
		next_cycle();
	endtask

	task automatic note_scroll();
		int born;
		int x;
		int y_old;
		rgb_t col;
		apply_reset();
		x = int'(LANE_X[0]) + 54;
		spawn_note(LANE_LEFT, born);
		y_old = FRAME_Y + 36 + offset_at(born, cycles);
		sample_pixel(x, y_old, col);
		check_value(col, COL_RED, "new left note at its computed offset");
		for (int n = 0; n < 40 * STEP; n++)
			next_cycle();
		sample_pixel(x, y_old, col);
		check_value(col, COL_BG, "old note position after 40 steps");
		sample_pixel(x, FRAME_Y + 36 + offset_at(born, cycles), col);
		check_value(col, COL_RED, "left note at its new computed offset");
	endtask

	task automatic judge_grades();
		lane_t lane;
		int born;
		int targets [3];
		judge_t seen;
		grade_t want;
		rgb_t col;
		targets = '{105, 55, 15};   // middle of miss, early, on-time
		apply_reset();
		lane = lane_t'($urandom_range(3, 0));
		for (int i = 0; i < 3; i++)
		begin
			spawn_note(lane, born);
			wait_offset(born, targets[i]);
			want = grade_for(offset_at(born, cycles));
			press_expect_judge(lane, seen);
			check_value(seen.lane, lane, "lane of the judge pulse");
			check_value(seen.grade, want, "grade of the judge pulse");
			sample_pixel(30, 30, col);
			check_value(col, grade_colour(want), "grade square colour");
		end
		press_expect_none(lane_t'((int'(lane) + 1 + $urandom_range(2, 0)) % 4));
	endtask

	task automatic silent_expiry();
		lane_t lane;
		int first_born;
		int born;
		logic freed;
		apply_reset();
		lane = lane_t'($urandom_range(3, 0));
		spawn_note(lane, first_born);
		spawn_note(lane, born);
		spawn_note(lane, born);
		spawn_lane = lane;
		freed = 1'b0;
		for (int n = 0; n < START_OFFSET * STEP + 20 && !freed; n++)
		begin
			next_cycle();
			check_value(judge_valid, 1'b0, "judge pulse during silent expiry");
			freed = spawn_ready;
		end
		if (!freed)
			fail_stop("a full lane never freed a slot by expiry");
		check_value(cycles - first_born, START_OFFSET * STEP, "lifetime of an unjudged note");
	endtask

	initial
	begin
		#(2 * CLK_HALF * RUN_LIMIT);
		$display("the run did not finish within the cycle limit");
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial
	begin
		int order [5];
		int pick;
		int tmp;
		int seed;
		clk = 1'b0;
		rst_n = 1'b0;
		spawn_valid = 1'b0;
		spawn_lane = LANE_LEFT;
		pad = '1;
		pix_valid = 1'b0;
		pix = '0;
		cycles = 0;
		seed = 32'h9b04a063;
		void'($urandom(seed));
		for (int i = 0; i < 5; i++)
			order[i] = i;
		for (int i = 4; i > 0; i--)
		begin
			pick = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[pick];
			order[pick] = tmp;
		end
		// each test resets the DUT, so any order works
		for (int i = 0; i < 5; i++)
			case (order[i])
				0: reset_and_background();
				1: full_lane_back_pressure();
				2: note_scroll();
				3: judge_grades();
				default: silent_expiry();
			endcase
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
rhythm_pkg.sv
note_lanes.sv
target_painter.sv
note_painter.sv
pixel_mixer.sv
rhythm_display.sv
tb_rhythm_display.sv
